//--- soc_ctrl_pkg.sv
/*
 * shared definitions of the soc control register block
 * bus widths, register map bounds, info word contents and reset values
 */
`default_nettype none

package soc_ctrl_pkg;

  // apb3 bus widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;

  // the block answers a 4 KiB window starting here
  localparam logic [addr_width-1:0] base_addr = 32'h1A10_4000;

  // system shape reported through the info word
  localparam int unsigned n_cores    = 8;
  localparam int unsigned n_clusters = 1;

  // core count in the upper half and cluster count in the lower half
  localparam logic [data_width-1:0] info_word = {16'(n_cores), 16'(n_clusters)};

  // core-reset registers and their reset value
  localparam int unsigned n_core_res     = 4;
  localparam int unsigned core_idx_width = $clog2(n_core_res);
  typedef logic [n_core_res-1:0][data_width-1:0] core_res_t;
  localparam core_res_t core_res_init = '0;

  // a word index covers the full window of 1024 words
  localparam int unsigned idx_width = 10;

  // region bounds as byte offsets into the window
  localparam logic [11:0] info_off = 12'h010;
  localparam logic [11:0] rw_lo    = 12'h080;
  localparam logic [11:0] rw_hi    = 12'h08F;
  localparam logic [11:0] win_hi   = 12'hFFF;

  // one-hot region select produced by the decoder
  // reg_none marks an address outside the window
  typedef enum logic [3:0] {
    reg_none = 4'b0001,
    reg_zero = 4'b0010,
    reg_info = 4'b0100,
    reg_rw   = 4'b1000
  } region_e;

endpackage

`default_nettype wire

//--- soc_ctrl_decode.sv
/*
 * soc control address decoder
 * classifies an apb address into a region and a word index within it
 */
`default_nettype none

module soc_ctrl_decode (
  input  logic [soc_ctrl_pkg::addr_width-1:0] paddr,
  output soc_ctrl_pkg::region_e               region,
  output logic [soc_ctrl_pkg::idx_width-1:0]  word_idx
);

  import soc_ctrl_pkg::*;

  // byte offset relative to the window base
  // an address below the base wraps around to a large offset
  logic [addr_width-1:0] offset;
  logic                  in_win;
  logic [idx_width-1:0]  word;

  assign offset = paddr - base_addr;

  // anything beyond the last byte of the window is unmapped
  assign in_win = (offset <= addr_width'(win_hi));

  // the two low address bits are ignored since all accesses are full words
  assign word = offset[11:2];

  always_comb begin
    region   = reg_none;
    word_idx = '0;
    if (in_win) begin
      if (word == info_off[11:2]) begin
        // single info word, its index is always zero
        region   = reg_info;
        word_idx = word - info_off[11:2];
      end else if (word >= rw_lo[11:2] && word <= rw_hi[11:2]) begin
        // core-reset registers, indexed from the first one
        region   = reg_rw;
        word_idx = word - rw_lo[11:2];
      end else begin
        // reserved words keep the window index
        // the read-only bank answers all of them the same way
        region   = reg_zero;
        word_idx = word;
      end
    end
  end

endmodule

`default_nettype wire

//--- soc_ctrl_ro_bank.sv
/*
 * soc control read-only bank
 * answers the info word and the reserved words, and refuses writes to them
 */
`default_nettype none

module soc_ctrl_ro_bank (
  input  soc_ctrl_pkg::region_e                region,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  output logic [soc_ctrl_pkg::data_width-1:0]  ro_rdata,
  output logic                                 ro_err
);

  import soc_ctrl_pkg::*;

  logic access;
  logic ro_hit;

  // the access phase of an apb3 transfer
  assign access = psel & penable;

  // both read-only regions share the same write policy
  assign ro_hit = (region == reg_info) || (region == reg_zero);

  // the info word is a constant and every reserved word reads as zero
  always_comb begin
    if (region == reg_info) begin
      ro_rdata = info_word;
    end else begin
      ro_rdata = '0;
    end
  end

  // a write to any read-only word is refused in its access cycle
  // a read of the same words completes without error
  assign ro_err = access & pwrite & ro_hit;

endmodule

`default_nettype wire

//--- soc_ctrl_rw_bank.sv
/*
 * soc control read/write bank
 * holds the core-reset registers with apb writes, readback and outputs
 */
`default_nettype none

module soc_ctrl_rw_bank (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  soc_ctrl_pkg::region_e               region,
  input  logic [soc_ctrl_pkg::idx_width-1:0]  word_idx,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [soc_ctrl_pkg::data_width-1:0] pwdata,
  output logic [soc_ctrl_pkg::data_width-1:0] rw_rdata,
  output soc_ctrl_pkg::core_res_t             core_res
);

  import soc_ctrl_pkg::*;

  logic [core_idx_width-1:0] sel;
  logic                      wr_en;

  // the decoder hands out indices 0 to n_core_res-1 for reg_rw
  assign sel = word_idx[core_idx_width-1:0];

  // a write lands on the access cycle
  // with pready always high that cycle is also the last one of the transfer
  assign wr_en = psel & penable & pwrite & (region == reg_rw);

  // register update at the edge that ends the access cycle
  // the new value is visible on core_res from the next cycle on
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      core_res <= core_res_init;
    end else if (wr_en) begin
      core_res[sel] <= pwdata;
    end
  end

  // readback is combinational from the current index
  // the response merge only passes it on for reg_rw
  assign rw_rdata = core_res[sel];

endmodule

`default_nettype wire

//--- soc_ctrl_resp.sv
/*
 * soc control response merge
 * selects the bank answer for prdata and builds pslverr
 */
`default_nettype none

module soc_ctrl_resp (
  input  soc_ctrl_pkg::region_e               region,
  input  logic                                psel,
  input  logic                                penable,
  input  logic [soc_ctrl_pkg::data_width-1:0] ro_rdata,
  input  logic                                ro_err,
  input  logic [soc_ctrl_pkg::data_width-1:0] rw_rdata,
  output logic [soc_ctrl_pkg::data_width-1:0] prdata,
  output logic                                pslverr
);

  import soc_ctrl_pkg::*;

  logic access;
  logic err;

  assign access = psel & penable;

  // pick the bank that owns the decoded region
  always_comb begin
    case (region)
      reg_info, reg_zero: begin
        prdata = ro_rdata;
        err    = ro_err;
      end
      reg_rw: begin
        // every access to the core-reset registers is legal
        prdata = rw_rdata;
        err    = 1'b0;
      end
      default: begin
        // an unmapped address fails the transfer with zero read data
        prdata = '0;
        err    = 1'b1;
      end
    endcase
  end

  // pslverr only means something in the access cycle
  assign pslverr = access & err;

endmodule

`default_nettype wire

//--- soc_ctrl_regs.sv
/*
 * top level of the soc control register block
 * apb3 slave with zero wait states, decode into banks and response merge
 */
`default_nettype none

module soc_ctrl_regs (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [soc_ctrl_pkg::addr_width-1:0] paddr,
  input  logic [soc_ctrl_pkg::data_width-1:0] pwdata,
  output logic [soc_ctrl_pkg::data_width-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr,
  output soc_ctrl_pkg::core_res_t             core_res
);

  import soc_ctrl_pkg::*;

  region_e               region;
  logic [idx_width-1:0]  word_idx;
  logic [data_width-1:0] ro_rdata;
  logic                  ro_err;
  logic [data_width-1:0] rw_rdata;

  // without wait states every access cycle completes the transfer
  assign pready = 1'b1;

  // decode step maps the address to a region and a word index
  soc_ctrl_decode i_decode (
    .paddr    (paddr),
    .region   (region),
    .word_idx (word_idx)
  );

  // execute step for the info word and all reserved words
  soc_ctrl_ro_bank i_ro_bank (
    .region   (region),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .ro_rdata (ro_rdata),
    .ro_err   (ro_err)
  );

  // execute step for the core-reset registers
  soc_ctrl_rw_bank i_rw_bank (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .region   (region),
    .word_idx (word_idx),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .rw_rdata (rw_rdata),
    .core_res (core_res)
  );

  // result step puts read data and error back onto the bus
  soc_ctrl_resp i_resp (
    .region   (region),
    .psel     (psel),
    .penable  (penable),
    .ro_rdata (ro_rdata),
    .ro_err   (ro_err),
    .rw_rdata (rw_rdata),
    .prdata   (prdata),
    .pslverr  (pslverr)
  );

endmodule

`default_nettype wire

//--- soc_ctrl_asserts.sv
/*
 * checker bound into the soc control register block top level
 * tracks the core-reset registers and compares each apb transfer with the map
 */
`default_nettype none

module soc_ctrl_asserts (
  input logic                                clk_i,
  input logic                                rst_n,
  input logic                                psel,
  input logic                                penable,
  input logic                                pwrite,
  input logic [soc_ctrl_pkg::addr_width-1:0] paddr,
  input logic [soc_ctrl_pkg::data_width-1:0] pwdata,
  input logic [soc_ctrl_pkg::data_width-1:0] prdata,
  input logic                                pready,
  input logic                                pslverr,
  input soc_ctrl_pkg::core_res_t             core_res
);
  timeunit 1ns;
  timeprecision 100ps;

  import soc_ctrl_pkg::*;

  // the testbench watches this failure count
  int unsigned               n_fail = 0;
  core_res_t                 shadow;
  logic [addr_width-1:0]     off;
  logic [11:0]               woff;
  logic                      access;
  logic                      in_win;
  logic                      hit_info;
  logic                      hit_rw;
  logic [core_idx_width-1:0] idx;
  logic [data_width-1:0]     exp_rdata;
  logic                      exp_err;

  assign access = psel & penable;

  // the map is a 4 KiB window where the two low address bits are ignored
  assign off      = paddr - base_addr;
  assign in_win   = off < 32'h0000_1000;
  assign woff     = {off[11:2], 2'b00};
  assign hit_info = in_win && (woff == info_off);
  assign hit_rw   = in_win && (woff >= rw_lo) && (woff <= rw_hi);
  assign idx      = core_idx_width'((woff - rw_lo) >> 2);

  // only the info word and the core-reset registers read as nonzero
  always_comb begin
    exp_rdata = '0;
    if (hit_info) begin
      exp_rdata = info_word;
    end else if (hit_rw) begin
      exp_rdata = shadow[idx];
    end
  end

  // writes only succeed on the core-reset registers
  assign exp_err = !in_win || (pwrite && !hit_rw);

  // shadow copy follows every completed register write
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      shadow <= core_res_init;
    end else if (access && pwrite && hit_rw) begin
      shadow[idx] <= pwdata;
    end
  end

  a_pready: assert property (@(posedge clk_i) disable iff (!rst_n) access |-> pready)
    else begin
      n_fail++;
      $error("pready is low in an access cycle");
    end

  // an error response only ever shows up in the access cycle
  a_err_idle: assert property (@(posedge clk_i) disable iff (!rst_n) !access |-> !pslverr)
    else begin
      n_fail++;
      $error("pslverr is high outside an access cycle");
    end

  a_err: assert property (@(posedge clk_i) disable iff (!rst_n) access |-> pslverr == exp_err)
    else begin
      n_fail++;
      $error("Mismatch pslverr: got 0x%0h, expected 0x%0h", $sampled(pslverr),
             $sampled(exp_err));
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n) access |-> prdata == exp_rdata)
    else begin
      n_fail++;
      $error("Mismatch prdata: got 0x%08h, expected 0x%08h", $sampled(prdata),
             $sampled(exp_rdata));
    end

  // the register outputs follow the shadow copy in every cycle including right after reset
  a_core_res: assert property (@(posedge clk_i) disable iff (!rst_n) core_res == shadow)
    else begin
      n_fail++;
      $error("Mismatch core_res: got 0x%032h, expected 0x%032h", $sampled(core_res),
             $sampled(shadow));
    end

endmodule

`default_nettype wire

//--- tb_soc_ctrl_regs.sv
/*
 * testbench for the soc control register block
 * directed region sweep and random apb transfers, judged by the bound checker
 */
`default_nettype none

module tb_soc_ctrl_regs;
  timeunit 1ns;
  timeprecision 100ps;

  import soc_ctrl_pkg::*;

  // each transfer takes three cycles and the run issues fewer than 600 of them
  localparam int unsigned n_random   = 500;
  localparam int unsigned max_cycles = 4 * 600 + 100;

  // offsets at each region boundary up to the first byte past the window
  localparam logic [addr_width-1:0] sweep_off [9] = '{
    32'h00C, 32'h010, 32'h014, 32'h07C, 32'h080, 32'h08C, 32'h090, 32'hFFC, 32'h1000
  };

  logic                  clk_i = 1'b0;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [addr_width-1:0] paddr;
  logic [data_width-1:0] pwdata;
  logic [data_width-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  core_res_t             core_res;
  int unsigned           cycles = 0;

  always #4 clk_i = ~clk_i;

  soc_ctrl_regs u_soc_ctrl_regs (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .core_res (core_res)
  );

  bind soc_ctrl_regs soc_ctrl_asserts i_asserts (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .core_res (core_res)
  );

  // idle cycle, setup cycle and then access cycles until pready is high
  task automatic apb_transfer(input logic [addr_width-1:0] addr, input logic write,
                              input logic [data_width-1:0] data);
    @(negedge clk_i);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk_i);
    penable = 1'b1;
    @(posedge clk_i);
    while (!pready) @(posedge clk_i);
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // addresses fall inside and around the window with extra weight on the mapped words
  task automatic random_transfer();
    logic [addr_width-1:0] addr;
    int unsigned           kind;
    kind = $urandom_range(0, 3);
    case (kind)
      0: addr = base_addr + rw_lo + 4 * $urandom_range(0, n_core_res - 1) + $urandom_range(0, 3);
      1: addr = base_addr + info_off;
      2: addr = base_addr + $urandom_range(0, 32'hFFF);
      default: addr = base_addr - 32'h100 + $urandom_range(0, 32'h1200);
    endcase
    apb_transfer(addr, 1'($urandom_range(0, 1)), $urandom());
  endtask

  // the checker raises its counter at the first failed assertion
  always @(u_soc_ctrl_regs.i_asserts.n_fail) begin
    if (u_soc_ctrl_regs.i_asserts.n_fail != 0) begin
      $display("=== FAIL ===");
      $fatal(1, "the checker reported a failed assertion");
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("=== FAIL ===");
      $fatal(1, "timeout, the run did not finish within %0d cycles", max_cycles);
    end
  end

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(62));
    repeat (2) @(negedge clk_i);
    rst_n = 1'b1;

    // every core-reset register reads its reset value
    for (int i = 0; i < n_core_res; i++) begin
      apb_transfer(base_addr + rw_lo + 4 * i, 1'b0, '0);
    end

    // write one distinct value per register and read all back to see the others held
    for (int i = 0; i < n_core_res; i++) begin
      apb_transfer(base_addr + rw_lo + 4 * i, 1'b1, 32'hC0DE_0000 + i);
    end
    for (int i = 0; i < n_core_res; i++) begin
      apb_transfer(base_addr + rw_lo + 4 * i, 1'b0, '0);
    end

    // read, write and read again at each region boundary
    foreach (sweep_off[i]) begin
      apb_transfer(base_addr + sweep_off[i], 1'b0, '0);
      apb_transfer(base_addr + sweep_off[i], 1'b1, $urandom());
      apb_transfer(base_addr + sweep_off[i], 1'b0, '0);
    end

    repeat (n_random) random_transfer();
    repeat (2) @(negedge clk_i);

    if (u_soc_ctrl_regs.i_asserts.n_fail == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1, "the checker reported failed assertions");
    end
  end

endmodule

`default_nettype wire

//--- compile.f
soc_ctrl_pkg.sv
soc_ctrl_decode.sv
soc_ctrl_ro_bank.sv
soc_ctrl_rw_bank.sv
soc_ctrl_resp.sv
soc_ctrl_regs.sv
soc_ctrl_asserts.sv
tb_soc_ctrl_regs.sv
